// ==== src/sync_fifo_defines.svh ====
// sync fifo sizing macros

`ifndef SYNC_FIFO_DEFINES_SVH
`define SYNC_FIFO_DEFINES_SVH

// ---------------------------------------------------------------------
// storage geometry
// ---------------------------------------------------------------------
`define FIFO_DATA_W      18   // bits per stored word
`define FIFO_ADDR_W      4    // memory address bits
`define FIFO_DEPTH       16   // entries, 2**FIFO_ADDR_W

// ---------------------------------------------------------------------
// static flag thresholds, in words
// afull is set at or above FIFO_AFULL_VAL
// aempty is set below FIFO_AEMPTY_VAL
// ---------------------------------------------------------------------
`define FIFO_AFULL_VAL   12
`define FIFO_AEMPTY_VAL  4

`endif

// ==== src/sync_fifo_pkg.sv ====
// sync fifo shared types

`include "sync_fifo_defines.svh"

package sync_fifo_pkg;

   // ------------------------------------------------------------------
   // vector types sized from the defines header
   // ------------------------------------------------------------------

   // one stored word
   typedef logic [`FIFO_DATA_W-1:0] fifo_data_t;

   // memory address, write and read side alike
   typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

   // occupancy 0..FIFO_DEPTH, one extra bit so full fits
   typedef logic [`FIFO_ADDR_W:0]   fifo_level_t;

endpackage

// ==== src/fifo_occupancy.sv ====
// fifo occupancy counter and flags

`timescale 1ns/10ps

`include "sync_fifo_defines.svh"

module fifo_occupancy (
   input  logic                       pos_clk,
   input  logic                       aresetn,      // async, active low
   input  logic                       wr_en_i,      // write strobe
   input  logic                       rd_en_i,      // read strobe
   output logic                       wr_accept_o,  // write taken this edge
   output logic                       rd_accept_o,  // read taken this edge
   output sync_fifo_pkg::fifo_level_t level_o,      // words stored
   output logic                       full_o,
   output logic                       empty_o,
   output logic                       afull_o,
   output logic                       aempty_o,
   output logic                       wack_o,       // one cycle after accepted write
   output logic                       overflow_o,   // write met full
   output logic                       underflow_o   // read met empty
);

   // ------------------------------------------------------------------
   // thresholds in level width
   // ------------------------------------------------------------------
   localparam sync_fifo_pkg::fifo_level_t lvl_full =
      sync_fifo_pkg::fifo_level_t'(`FIFO_DEPTH);
   localparam sync_fifo_pkg::fifo_level_t lvl_afull =
      sync_fifo_pkg::fifo_level_t'(`FIFO_AFULL_VAL);
   localparam sync_fifo_pkg::fifo_level_t lvl_aempty =
      sync_fifo_pkg::fifo_level_t'(`FIFO_AEMPTY_VAL);

   sync_fifo_pkg::fifo_level_t level_nxt;   // count after this edge

   // ------------------------------------------------------------------
   // strobe acceptance
   // ------------------------------------------------------------------
   // flags are registered, so a strobe is judged against the state
   // the source could see when it raised it
   assign wr_accept_o = wr_en_i & ~full_o;
   assign rd_accept_o = rd_en_i & ~empty_o;

   // ------------------------------------------------------------------
   // next occupancy
   // ------------------------------------------------------------------
   always_comb begin
      level_nxt = level_o;                   // both or neither, hold
      case ({wr_accept_o, rd_accept_o})
         2'b10:   level_nxt = level_o + 1'b1; // write only
         2'b01:   level_nxt = level_o - 1'b1; // read only
         default: level_nxt = level_o;
      endcase
   end

   // ------------------------------------------------------------------
   // level and status flags
   // ------------------------------------------------------------------
   // every flag comes from level_nxt so it lines up with level_o
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_o  <= '0;
         full_o   <= 1'b0;
         empty_o  <= 1'b1;   // starts empty
         afull_o  <= 1'b0;
         aempty_o <= 1'b1;
      end else begin
         level_o  <= level_nxt;
         full_o   <= (level_nxt == lvl_full);
         empty_o  <= (level_nxt == '0);
         afull_o  <= (level_nxt >= lvl_afull);
         aempty_o <= (level_nxt <  lvl_aempty);
      end
   end

   // ------------------------------------------------------------------
   // handshake and error pulses
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         wack_o      <= wr_accept_o;
         // rejected strobes only, state untouched above
         overflow_o  <= wr_en_i & full_o;
         underflow_o <= rd_en_i & empty_o;
      end
   end

   // ------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------
   // full and empty are exclusive for any nonzero depth
   a_full_empty_excl : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         !(full_o && empty_o))
      else $error("full_o and empty_o high together");

   // counter never runs past the storage
   a_level_bound : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         level_o <= lvl_full)
      else $error("level_o above depth: %0d", level_o);

   // no read handed to the memory while nothing is stored
   a_no_read_empty : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         rd_accept_o |-> (!empty_o && level_o != '0))
      else $error("read accepted while empty");

endmodule

// ==== src/fifo_addr_gen.sv ====
// fifo write and read pointers

`timescale 1ns/10ps

`include "sync_fifo_defines.svh"

module fifo_addr_gen (
   input  logic                      pos_clk,
   input  logic                      aresetn,
   input  logic                      wr_accept_i,  // step write pointer
   input  logic                      rd_accept_i,  // step read pointer
   output sync_fifo_pkg::fifo_addr_t wr_addr_o,
   output sync_fifo_pkg::fifo_addr_t rd_addr_o
);

   localparam sync_fifo_pkg::fifo_addr_t addr_last =
      sync_fifo_pkg::fifo_addr_t'(`FIFO_DEPTH - 1);

   // step by one, wrap at the last entry
   // explicit wrap keeps a non power of two depth working
   function automatic sync_fifo_pkg::fifo_addr_t ptr_next(
      input sync_fifo_pkg::fifo_addr_t ptr);
      ptr_next = (ptr == addr_last) ? '0 : ptr + 1'b1;
   endfunction

   // ------------------------------------------------------------------
   // pointer registers
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_addr_o <= '0;
         rd_addr_o <= '0;
      end else begin
         if (wr_accept_i)
            wr_addr_o <= ptr_next(wr_addr_o);
         if (rd_accept_i)
            rd_addr_o <= ptr_next(rd_addr_o);
      end
   end

   // ------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------
   a_wr_ptr_step : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         !$stable(wr_addr_o) |-> $past(wr_accept_i))
      else $error("write pointer moved without accept");

   a_rd_ptr_step : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         !$stable(rd_addr_o) |-> $past(rd_accept_i))
      else $error("read pointer moved without accept");

endmodule

// ==== src/fifo_ram.sv ====
// fifo register array storage

`timescale 1ns/10ps

`include "sync_fifo_defines.svh"

module fifo_ram (
   input  logic                      pos_clk,
   input  logic                      aresetn,
   input  logic                      wr_accept_i,
   input  sync_fifo_pkg::fifo_addr_t wr_addr_i,
   input  sync_fifo_pkg::fifo_data_t wr_data_i,
   input  logic                      rd_accept_i,
   input  sync_fifo_pkg::fifo_addr_t rd_addr_i,
   output sync_fifo_pkg::fifo_data_t rd_data_o,   // held until next read
   output logic                      dvld_o       // rd_data_o fresh
);

   sync_fifo_pkg::fifo_data_t mem [`FIFO_DEPTH];  // storage array

   // ------------------------------------------------------------------
   // write port
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk) begin
      if (wr_accept_i)
         mem[wr_addr_i] <= wr_data_i;
   end

   // ------------------------------------------------------------------
   // registered read port
   // ------------------------------------------------------------------
   // no same-address hazard, a read never targets the write slot
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_data_o <= '0;
         dvld_o    <= 1'b0;
      end else begin
         dvld_o <= rd_accept_i;              // one pulse per read
         if (rd_accept_i)
            rd_data_o <= mem[rd_addr_i];
      end
   end

   // valid only ever follows an accepted read
   a_dvld_follows_read : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         dvld_o |-> $past(rd_accept_i))
      else $error("dvld_o without a read the cycle before");

endmodule

// ==== src/sync_fifo.sv ====
// single clock fifo top level

`timescale 1ns/10ps

module sync_fifo (
   input  logic                       pos_clk,
   input  logic                       aresetn,
   input  logic                       wr_en_i,
   input  sync_fifo_pkg::fifo_data_t  wr_data_i,
   input  logic                       rd_en_i,
   output sync_fifo_pkg::fifo_data_t  rd_data_o,
   output logic                       dvld_o,
   output logic                       wack_o,
   output sync_fifo_pkg::fifo_level_t level_o,
   output logic                       full_o,
   output logic                       empty_o,
   output logic                       afull_o,
   output logic                       aempty_o,
   output logic                       overflow_o,
   output logic                       underflow_o
);

   logic                      wr_accept;   // strobes past the flags
   logic                      rd_accept;
   sync_fifo_pkg::fifo_addr_t wr_addr;
   sync_fifo_pkg::fifo_addr_t rd_addr;

   // ------------------------------------------------------------------
   // control, counting and flags
   // ------------------------------------------------------------------
   fifo_occupancy u_occupancy (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .rd_en_i     (rd_en_i),
      .wr_accept_o (wr_accept),
      .rd_accept_o (rd_accept),
      .level_o     (level_o),
      .full_o      (full_o),
      .empty_o     (empty_o),
      .afull_o     (afull_o),
      .aempty_o    (aempty_o),
      .wack_o      (wack_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // pointers
   fifo_addr_gen u_addr_gen (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .wr_addr_o   (wr_addr),
      .rd_addr_o   (rd_addr)
   );

   // storage and read register
   fifo_ram u_ram (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .wr_addr_i   (wr_addr),
      .wr_data_i   (wr_data_i),
      .rd_accept_i (rd_accept),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data_o),
      .dvld_o      (dvld_o)
   );

endmodule

// ==== dv/tb_sync_fifo.sv ====
// sync fifo testbench

`timescale 1ns/10ps

`include "sync_fifo_defines.svh"

module tb_sync_fifo;

   localparam string TEST_FILE = "dv/sync_fifo_tests.txt";

   // ------------------------------------------------------------------
   // dut signals
   // ------------------------------------------------------------------
   logic                       pos_clk = 1'b0;
   logic                       aresetn;
   logic                       wr_en_i;
   sync_fifo_pkg::fifo_data_t  wr_data_i;
   logic                       rd_en_i;
   sync_fifo_pkg::fifo_data_t  rd_data_o;
   logic                       dvld_o;
   logic                       wack_o;
   sync_fifo_pkg::fifo_level_t level_o;
   logic                       full_o;
   logic                       empty_o;
   logic                       afull_o;
   logic                       aempty_o;
   logic                       overflow_o;
   logic                       underflow_o;

   // stimulus table with one entry per cycle
   bit                         st_wr[$];
   bit                         st_rd[$];
   bit                         st_rand[$];    // data column was r
   sync_fifo_pkg::fifo_data_t  st_data[$];
   int                         n_lines = 0;
   bit                         load_done = 1'b0;

   // reference model state starting at the reset values
   sync_fifo_pkg::fifo_data_t  model_q[$];
   sync_fifo_pkg::fifo_level_t m_level = '0;
   sync_fifo_pkg::fifo_data_t  exp_rdata = '0;
   logic                       exp_wack = 1'b0;
   logic                       exp_dvld = 1'b0;
   logic                       exp_ovf = 1'b0;
   logic                       exp_udf = 1'b0;
   logic                       exp_full = 1'b0;
   logic                       exp_empty = 1'b1;
   logic                       exp_afull = 1'b0;
   logic                       exp_aempty = 1'b1;
   logic                       m_full;        // model scratch per edge
   logic                       m_empty;
   logic                       wr_ok;
   logic                       rd_ok;
   bit                         model_on = 1'b0;
   bit                         check_on = 1'b0;

   int   value_errors = 0;
   int   other_errors = 0;

   always #4 pos_clk = ~pos_clk;   // 8 ns period

   sync_fifo u_dut (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .wr_data_i   (wr_data_i),
      .rd_en_i     (rd_en_i),
      .rd_data_o   (rd_data_o),
      .dvld_o      (dvld_o),
      .wack_o      (wack_o),
      .level_o     (level_o),
      .full_o      (full_o),
      .empty_o     (empty_o),
      .afull_o     (afull_o),
      .aempty_o    (aempty_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   task automatic report_mismatch(input string sig_name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      value_errors++;
      $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h",
               $time, sig_name, exp_v, act_v);
   endtask

   // true when the line holds an r token
   function automatic bit line_has_rand(input string s);
      bit found;
      found = 1'b0;
      for (int i = 0; i < s.len(); i++)
         if (s.getc(i) == "r")
            found = 1'b1;
      return found;
   endfunction

   task automatic load_tests();
      int          fd;
      int          n_fields;
      int          w_val;
      int          r_val;
      logic [31:0] d_val;
      string       line_s;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         other_errors++;
         $display("could not open stimulus file %s", TEST_FILE);
      end else begin
         while ($fgets(line_s, fd) != 0) begin
            d_val = '0;
            n_fields = $sscanf(line_s, "%d %d %h", w_val, r_val, d_val);
            if (n_fields >= 2) begin      // comment and blank lines give 0
               st_wr.push_back(w_val != 0);
               st_rd.push_back(r_val != 0);
               st_data.push_back(sync_fifo_pkg::fifo_data_t'(d_val));
               st_rand.push_back(n_fields == 2);
               if (n_fields == 2 && !line_has_rand(line_s)) begin
                  other_errors++;
                  $display("stimulus line without a data value: %s", line_s);
               end
            end
         end
         $fclose(fd);
      end
      n_lines = st_wr.size();
      load_done = 1'b1;
   endtask

   // fixed reset value of every output
   task automatic check_reset_values();
      if (level_o !== '0)       report_mismatch("level_o", 32'd0, 32'(level_o));
      if (full_o !== 1'b0)      report_mismatch("full_o", 32'd0, 32'(full_o));
      if (empty_o !== 1'b1)     report_mismatch("empty_o", 32'd1, 32'(empty_o));
      if (afull_o !== 1'b0)     report_mismatch("afull_o", 32'd0, 32'(afull_o));
      if (aempty_o !== 1'b1)    report_mismatch("aempty_o", 32'd1, 32'(aempty_o));
      if (wack_o !== 1'b0)      report_mismatch("wack_o", 32'd0, 32'(wack_o));
      if (dvld_o !== 1'b0)      report_mismatch("dvld_o", 32'd0, 32'(dvld_o));
      if (overflow_o !== 1'b0)  report_mismatch("overflow_o", 32'd0, 32'(overflow_o));
      if (underflow_o !== 1'b0) report_mismatch("underflow_o", 32'd0, 32'(underflow_o));
      if (rd_data_o !== '0)     report_mismatch("rd_data_o", 32'd0, 32'(rd_data_o));
   endtask

   // ------------------------------------------------------------------
   // reference model stepping on the edge that samples the strobes
   // ------------------------------------------------------------------
   always @(posedge pos_clk) begin
      if (model_on) begin
         m_full  = (m_level == `FIFO_DEPTH);   // flags of the model level
         m_empty = (m_level == 0);
         wr_ok   = wr_en_i && !m_full;
         rd_ok   = rd_en_i && !m_empty;
         exp_wack = wr_ok;
         exp_dvld = rd_ok;
         exp_ovf  = wr_en_i && m_full;           // dropped write
         exp_udf  = rd_en_i && m_empty;          // dropped read
         if (rd_ok)
            exp_rdata = model_q.pop_front();     // head leaves first
         if (wr_ok)
            model_q.push_back(wr_data_i);
         if (wr_ok && !rd_ok)
            m_level = sync_fifo_pkg::fifo_level_t'(m_level + 1);
         else if (rd_ok && !wr_ok)
            m_level = sync_fifo_pkg::fifo_level_t'(m_level - 1);
         // occupancy rule
         exp_full   = (m_level == `FIFO_DEPTH);
         exp_empty  = (m_level == 0);
         exp_afull  = (m_level >= `FIFO_AFULL_VAL);
         exp_aempty = (m_level <  `FIFO_AEMPTY_VAL);
      end
   end

   // ------------------------------------------------------------------
   // checks at mid cycle where outputs are settled
   // ------------------------------------------------------------------
   always @(negedge pos_clk) begin
      if (check_on) begin
         if (level_o !== m_level)
            report_mismatch("level_o", 32'(m_level), 32'(level_o));
         if (full_o !== exp_full)
            report_mismatch("full_o", 32'(exp_full), 32'(full_o));
         if (empty_o !== exp_empty)
            report_mismatch("empty_o", 32'(exp_empty), 32'(empty_o));
         if (afull_o !== exp_afull)
            report_mismatch("afull_o", 32'(exp_afull), 32'(afull_o));
         if (aempty_o !== exp_aempty)
            report_mismatch("aempty_o", 32'(exp_aempty), 32'(aempty_o));
         if (wack_o !== exp_wack)
            report_mismatch("wack_o", 32'(exp_wack), 32'(wack_o));
         if (dvld_o !== exp_dvld)
            report_mismatch("dvld_o", 32'(exp_dvld), 32'(dvld_o));
         if (overflow_o !== exp_ovf)
            report_mismatch("overflow_o", 32'(exp_ovf), 32'(overflow_o));
         if (underflow_o !== exp_udf)
            report_mismatch("underflow_o", 32'(exp_udf), 32'(underflow_o));
         if (rd_data_o !== exp_rdata)   // held between reads too
            report_mismatch("rd_data_o", 32'(exp_rdata), 32'(rd_data_o));
      end
   end

   // ------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------
   initial begin
      int idx;
      $timeformat(-9, 1, " ns", 0);
      void'($urandom(80));          // one seed for the whole run
      aresetn   = 1'b0;
      wr_en_i   = 1'b0;
      rd_en_i   = 1'b0;
      wr_data_i = '0;
      load_tests();
      repeat (3) @(posedge pos_clk);
      aresetn  <= 1'b1;
      model_on <= 1'b1;             // first model step on the next edge
      @(negedge pos_clk);
      check_reset_values();
      check_on = 1'b1;
      for (idx = 0; idx < n_lines; idx++) begin
         @(posedge pos_clk);
         wr_en_i   <= st_wr[idx];
         rd_en_i   <= st_rd[idx];
         wr_data_i <= st_rand[idx] ? sync_fifo_pkg::fifo_data_t'($urandom) : st_data[idx];
      end
      @(posedge pos_clk);
      wr_en_i <= 1'b0;              // go idle and let the last strobes settle
      rd_en_i <= 1'b0;
      repeat (3) @(posedge pos_clk);
      @(negedge pos_clk);
      $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog sized from the stimulus length
   initial begin
      wait (load_done);
      #((n_lines + 20) * 8);
      other_errors++;
      $display("timeout: run did not finish within %0d clock cycles", n_lines + 20);
      $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== sync_fifo.f ====
+incdir+src
src/sync_fifo_pkg.sv
src/fifo_occupancy.sv
src/fifo_addr_gen.sv
src/fifo_ram.sv
src/sync_fifo.sv
dv/tb_sync_fifo.sv

// ==== Makefile ====
# Verilator build and run of the sync fifo testbench

VERILATOR ?= verilator
TOP       ?= tb_sync_fifo
FLIST     ?= sync_fifo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# build, run from the project root, then search the log for the fail line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/sync_fifo_tests.txt ====
# columns: wr_en rd_en wr_data (hex, or r for a random word)
# one line per clock cycle, fields separated by spaces
0 1 0
0 1 0
1 1 00a01
1 0 r
1 0 r
1 0 1ffff
1 0 r
1 0 00005
1 0 r
1 0 r
1 0 2aaaa
1 0 r
1 0 15555
1 0 r
1 0 r
1 0 r
1 0 30303
1 0 r
1 0 3ffff
1 0 r
1 1 12345
1 1 r
1 1 r
1 1 0beef
1 1 r
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
0 1 0
1 1 r
0 1 0
1 0 r
1 1 r
0 1 0
